//--- source/branch_resolve.sv
/*
 * control-transfer decode of the IF/ID instruction
 * produces targets, select conditions and the jal link write, all combinational
 */
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
	input  wire pipe_pkg::ifid_s       i_ifid,
	input  wire logic [31:0]           i_rs_val,
	input  wire logic [31:0]           i_rt_val,
	output pipe_pkg::redirect_s        o_redirect,
	output logic                       o_taken,
	output logic                       o_link_we,
	output logic [31:0]                o_link_addr
);

	import isa_pkg::*;

	// ==================================================
	// classify
	// ==================================================
	logic is_jr;
	logic is_j;
	logic is_jal;
	logic is_beq;
	logic is_bne;

	// jr lives under SPECIAL, decoded through the R view
	assign is_jr  = (i_ifid.instr.r.op == OP_SPECIAL) &&
	                (i_ifid.instr.r.funct == FN_JR);
	assign is_j   = (i_ifid.instr.j.op == OP_J);
	assign is_jal = (i_ifid.instr.j.op == OP_JAL);
	assign is_beq = (i_ifid.instr.i.op == OP_BEQ);
	assign is_bne = (i_ifid.instr.i.op == OP_BNE);

	// ==================================================
	// targets
	// ==================================================
	logic [31:0] br_offset;

	// sign-extended word offset
	assign br_offset = {{14{i_ifid.instr.i.imm[15]}}, i_ifid.instr.i.imm, 2'b00};

	// relative to the delay slot address
	assign o_redirect.addr_b  = i_ifid.pc4 + br_offset;
	// region of the delay slot
	assign o_redirect.addr_j  = {i_ifid.pc4[31:28], i_ifid.instr.j.index, 2'b00};
	assign o_redirect.addr_jr = i_rs_val;

	// ==================================================
	// conditions
	// ==================================================
	logic rs_eq_rt;

	assign rs_eq_rt = (i_rs_val == i_rt_val);

	assign o_redirect.con_b    = (is_beq && rs_eq_rt) || (is_bne && !rs_eq_rt);
	assign o_redirect.con_j[0] = is_j || is_jal;
	assign o_redirect.con_j[1] = is_jr;

	// any transfer that moves the PC off the sequential path
	assign o_taken = o_redirect.con_b || (|o_redirect.con_j);

	// ==================================================
	// link
	// ==================================================
	// return point skips the delay slot
	assign o_link_we   = is_jal;
	assign o_link_addr = i_ifid.pc4 + 32'd4;

endmodule

`default_nettype wire

//--- source/fetch.sv
/*
 * fetch stage with the PC, next-PC selection and the IF/ID register
 * the redirect bundle comes back combinationally from branch_resolve
 */
`include "mips_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input  wire logic                     i_clk,
	input  wire logic                     i_nrst,
	input  wire isa_pkg::instr_u          i_instr,
	input  wire pipe_pkg::redirect_s      i_redirect,
	output logic [`MIPS_IMEM_AW-1:0]      o_imem_addr,
	output pipe_pkg::ifid_s               o_ifid
);

	import pipe_pkg::*;

	// ==================================================
	// program counter
	// ==================================================
	logic [31:0] pc_q;
	logic [31:0] pc4;
	logic [31:0] pc_next;

	// single adder, shared by fall-through and IF/ID
	assign pc4 = pc_q + 32'd4;

	// fixed priority jr, then j/jal, then taken branch
	always_comb begin
		if (i_redirect.con_j[1]) begin
			pc_next = i_redirect.addr_jr;
		end else if (i_redirect.con_j[0]) begin
			pc_next = i_redirect.addr_j;
		end else if (i_redirect.con_b) begin
			pc_next = i_redirect.addr_b;
		end else begin
			pc_next = pc4;
		end
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			pc_q <= `MIPS_RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	// byte PC to word index
	assign o_imem_addr = pc_q[`MIPS_IMEM_AW+1:2];

	// ==================================================
	// IF/ID register
	// ==================================================
	ifid_s ifid_d;

	always_comb begin
		ifid_d.pc    = pc_q;
		ifid_d.pc4   = pc4;
		ifid_d.instr = i_instr;
	end

	// all zero decodes as a nop
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_ifid <= '0;
		end else begin
			o_ifid <= ifid_d;
		end
	end

endmodule

`default_nettype wire

//--- source/front_end.sv
/*
 * instruction front end top, fetch and instruction store feeding branch_resolve
 * operand values come from the rest of the core
 */
`include "mips_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module front_end (
	input  wire logic                  i_clk,
	input  wire logic                  i_nrst,
	input  wire pipe_pkg::imem_load_s  i_load,
	input  wire logic [31:0]           i_rs_val,
	input  wire logic [31:0]           i_rt_val,
	output pipe_pkg::ifid_s            o_ifid,
	output logic                       o_redirect,
	output logic                       o_link_we,
	output logic [31:0]                o_link_addr
);

	import isa_pkg::*;
	import pipe_pkg::*;

	// ==================================================
	// interconnect
	// ==================================================
	logic [`MIPS_IMEM_AW-1:0] imem_addr;
	instr_u                   imem_instr;
	redirect_s                redirect;

	fetch u_fetch (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_instr     (imem_instr),
		.i_redirect  (redirect),
		.o_imem_addr (imem_addr),
		.o_ifid      (o_ifid)
	);

	instr_mem u_instr_mem (
		.i_clk   (i_clk),
		.i_load  (i_load),
		.i_addr  (imem_addr),
		.o_instr (imem_instr)
	);

	// decodes what fetch registered last cycle
	branch_resolve u_branch_resolve (
		.i_ifid      (o_ifid),
		.i_rs_val    (i_rs_val),
		.i_rt_val    (i_rt_val),
		.o_redirect  (redirect),
		.o_taken     (o_redirect),
		.o_link_we   (o_link_we),
		.o_link_addr (o_link_addr)
	);

endmodule

`default_nettype wire

//--- source/instr_mem.sv
/*
 * word-addressed instruction store
 * loaded through the load port before the run, read combinationally by fetch
 */
`include "mips_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module instr_mem (
	input  wire logic                      i_clk,
	input  wire pipe_pkg::imem_load_s      i_load,
	input  wire logic [`MIPS_IMEM_AW-1:0]  i_addr,
	output isa_pkg::instr_u                o_instr
);

	import isa_pkg::*;

	// ==================================================
	// storage
	// ==================================================
	instr_u mem [`MIPS_IMEM_DEPTH];

	// load port write
	// new word visible to the read side after the edge
	always_ff @(posedge i_clk) begin
		if (i_load.we) begin
			mem[i_load.addr] <= i_load.data;
		end
	end

	// ==================================================
	// read side
	// ==================================================
	// same cycle as the PC
	assign o_instr = mem[i_addr];

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
/*
 * instruction set encodings and the decode views of one instruction word
 */
`default_nettype none

package isa_pkg;

	// ==================================================
	// primary opcodes
	// ==================================================
	// only control transfers are listed
	// anything else passes through as a plain instruction
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05
	} opcode_e;

	// funct field of SPECIAL instructions
	typedef enum logic [5:0] {
		FN_JR = 6'h08
	} funct_e;

	// ==================================================
	// instruction formats
	// ==================================================
	// register format
	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_view_s;

	// immediate format, branches use the offset here
	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_view_s;

	// jump format
	typedef struct packed {
		opcode_e     op;
		logic [25:0] index;
	} j_view_s;

	// one 32-bit word seen through all three formats
	typedef union packed {
		r_view_s r;
		i_view_s i;
		j_view_s j;
	} instr_u;

endpackage

`default_nettype wire

//--- source/mips_settings.svh
/*
 * build-wide constants for the instruction front end
 * include wherever the reset PC or store geometry is needed
 */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ==================================================
// program counter
// ==================================================
// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// ==================================================
// instruction store geometry
// ==================================================
// number of 32-bit words
`define MIPS_IMEM_DEPTH 256
// word address width, log2 of the depth
`define MIPS_IMEM_AW 8

`endif

//--- source/pipe_pkg.sv
/*
 * bundles passed between the front end stages and to the load port
 */
`include "mips_settings.svh"
`default_nettype none

package pipe_pkg;

	// IF/ID pipeline register contents
	typedef struct packed {
		logic [31:0]     pc;
		logic [31:0]     pc4;
		isa_pkg::instr_u instr;
	} ifid_s;

	// targets and select conditions fed back to fetch
	typedef struct packed {
		logic [31:0] addr_b;
		logic [31:0] addr_j;
		logic [31:0] addr_jr;
		logic        con_b;
		// bit 0 j or jal, bit 1 jr
		logic [1:0]  con_j;
	} redirect_s;

	// ==================================================
	// program load port
	// ==================================================
	// one word written per cycle while we is high
	typedef struct packed {
		logic                     we;
		logic [`MIPS_IMEM_AW-1:0] addr;
		logic [31:0]              data;
	} imem_load_s;

endpackage

`default_nettype wire

//--- sources.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch.sv
source/instr_mem.sv
source/branch_resolve.sv
source/front_end.sv
testbench/front_end_checker.sv
testbench/front_end_monitor.sv
testbench/tb_front_end.sv

//--- testbench/front_end_checker.sv
/*
 * concurrent assertions on the front end top ports
 * bound into every front_end instance at the bottom of this file
 */
`timescale 1ns/1ns
`default_nettype none

module front_end_checker (
	input  wire logic             i_clk,
	input  wire logic             i_nrst,
	input  wire pipe_pkg::ifid_s  i_ifid,
	input  wire logic             i_redirect,
	input  wire logic             i_link_we
);

	// failure counts, read by the testbench for its closing line
	int unsigned quiet_fails = 0;
	int unsigned link_fails  = 0;
	int unsigned step_fails  = 0;
	int unsigned fails;

	assign fails = quiet_fails + link_fails + step_fails;

	// ==================================================
	// properties
	// ==================================================
	// nop in IF/ID and no strobes while reset is held
	quiet_in_reset: assert property (@(posedge i_clk)
		!i_nrst |-> (i_ifid == '0) && !i_redirect && !i_link_we)
	else begin
		$error("front end outputs not quiet during reset");
		quiet_fails++;
	end

	// a link write only comes with jal, which always redirects
	link_with_redirect: assert property (@(posedge i_clk) disable iff (!i_nrst)
		i_link_we |-> i_redirect)
	else begin
		$error("link write strobe without a redirect");
		link_fails++;
	end

	// no transfer, so the instruction after the next one is sequential
	pc_steps_by_four: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!i_redirect |=> ##1 (i_ifid.pc == $past(i_ifid.pc) + 32'd4))
	else begin
		$error("IF/ID pc did not advance by 4 without a redirect");
		step_fails++;
	end

endmodule

bind front_end front_end_checker u_checker (
	.i_clk      (i_clk),
	.i_nrst     (i_nrst),
	.i_ifid     (o_ifid),
	.i_redirect (o_redirect),
	.i_link_we  (o_link_we)
);

`default_nettype wire

//--- testbench/front_end_monitor.sv
/*
 * watches the front end top ports and compares them with a reference model
 * keeps a shadow copy of the instruction store from the load port
 */
`include "mips_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module front_end_monitor (
	input  wire logic                  i_clk,
	input  wire logic                  i_nrst,
	input  wire pipe_pkg::imem_load_s  i_load,
	input  wire logic [31:0]           i_rs_val,
	input  wire logic [31:0]           i_rt_val,
	input  wire pipe_pkg::ifid_s       i_ifid,
	input  wire logic                  i_redirect,
	input  wire logic                  i_link_we,
	input  wire logic [31:0]           i_link_addr,
	output int unsigned                o_errors
);

	import isa_pkg::*;

	typedef struct packed {
		logic        taken;
		logic        link_we;
		logic [31:0] target;
		logic [31:0] link_addr;
	} expect_s;

	int unsigned errors = 0;
	logic [31:0] shadow [`MIPS_IMEM_DEPTH];

	assign o_errors = errors;

	always @(posedge i_clk) begin
		if (i_load.we) begin
			shadow[i_load.addr] <= i_load.data;
		end
	end

	// ==================================================
	// reference model
	// ==================================================
	function automatic expect_s predict(input logic [31:0] pc4, input logic [31:0] word,
			input logic [31:0] rs, input logic [31:0] rt);
		expect_s e;
		logic [31:0] offset;
		offset = {{14{word[15]}}, word[15:0], 2'b00};
		e = '0;
		e.link_addr = pc4 + 32'd4;
		case (word[31:26])
			OP_BEQ: begin
				e.taken  = (rs == rt);
				e.target = pc4 + offset;
			end
			OP_BNE: begin
				e.taken  = (rs != rt);
				e.target = pc4 + offset;
			end
			OP_J, OP_JAL: begin
				e.taken   = 1'b1;
				e.link_we = (word[31:26] == OP_JAL);
				e.target  = {pc4[31:28], word[25:0], 2'b00};
			end
			OP_SPECIAL: begin
				e.taken  = (word[5:0] == FN_JR);
				e.target = rs;
			end
			default: ;
		endcase
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	// ==================================================
	// comparison
	// ==================================================
	expect_s     exp_now;
	expect_s     exp_hist1;
	expect_s     exp_hist2;
	logic [31:0] pc_hist1;
	int unsigned seen = 0;

	always @(posedge i_clk) begin
		if (!i_nrst) begin
			seen = 0;
		end else begin
			exp_now = predict(i_ifid.pc4, i_ifid.instr, i_rs_val, i_rt_val);
			check_value("o_redirect", 32'(exp_now.taken), 32'(i_redirect));
			check_value("o_link_we", 32'(exp_now.link_we), 32'(i_link_we));
			if (exp_now.link_we) begin
				check_value("o_link_addr", exp_now.link_addr, i_link_addr);
			end
			if (seen == 0) begin
				check_value("o_ifid.pc", 32'd0, i_ifid.pc);
				check_value("o_ifid.pc4", 32'd0, i_ifid.pc4);
				check_value("o_ifid.instr", 32'd0, i_ifid.instr);
			end else begin
				check_value("o_ifid.pc4", i_ifid.pc + 32'd4, i_ifid.pc4);
				check_value("o_ifid.instr", shadow[i_ifid.pc[`MIPS_IMEM_AW+1:2]],
					i_ifid.instr);
			end
			if (seen == 1) begin
				check_value("o_ifid.pc", `MIPS_RESET_PC, i_ifid.pc);
			end
			// fall-through is the fetch PC of the next cycle plus 4
			if (seen >= 2) begin
				check_value("o_ifid.pc",
					exp_hist2.taken ? exp_hist2.target : pc_hist1 + 32'd4, i_ifid.pc);
			end
			exp_hist2 = exp_hist1;
			exp_hist1 = exp_now;
			pc_hist1  = i_ifid.pc;
			seen++;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_front_end.sv
/*
 * testbench top for the instruction front end
 * loads a generated program during reset, then drives operands each cycle
 */
`include "mips_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_front_end;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int PROG_LEN     = `MIPS_IMEM_DEPTH;
	localparam int RUN_CYCLES   = PROG_LEN + PROG_LEN / 2;
	localparam int RERUN_CYCLES = 32;
	localparam int WATCHDOG     = (PROG_LEN * 3 + 2 * RESET_CYCLES + 64) * CLK_PERIOD;

	logic        clk;
	logic        nrst;
	imem_load_s  load;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	ifid_s       ifid;
	logic        redirect;
	logic        link_we;
	logic [31:0] link_addr;
	int unsigned mon_errors;
	int unsigned total;

	front_end uut (
		.i_clk       (clk),
		.i_nrst      (nrst),
		.i_load      (load),
		.i_rs_val    (rs_val),
		.i_rt_val    (rt_val),
		.o_ifid      (ifid),
		.o_redirect  (redirect),
		.o_link_we   (link_we),
		.o_link_addr (link_addr)
	);

	front_end_monitor u_monitor (
		.i_clk       (clk),
		.i_nrst      (nrst),
		.i_load      (load),
		.i_rs_val    (rs_val),
		.i_rt_val    (rt_val),
		.i_ifid      (ifid),
		.i_redirect  (redirect),
		.i_link_we   (link_we),
		.i_link_addr (link_addr),
		.o_errors    (mon_errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==================================================
	// program image
	// ==================================================
	// first 16 words sequential, then a control pattern every 16 words
	// j at 10 lands on the jal of the next block
	// jal at 12 has jr in its delay slot
	function automatic logic [31:0] program_word(input logic [31:0] w);
		logic [31:0] plain;
		plain = {6'h08, 5'(w), 5'(w >> 3), 16'(w) ^ 16'ha5c3};
		if (w < 16) begin
			return plain;
		end
		case (w % 16)
			4:  return {OP_BEQ, 5'd1, 5'd2, 16'sd3};
			7:  return {OP_BNE, 5'd3, 5'd4, -16'sd6};
			10: return {OP_J, 26'((w + 18) % `MIPS_IMEM_DEPTH)};
			12: return {OP_JAL, 26'((w * 3 + 5) % `MIPS_IMEM_DEPTH)};
			13: return {OP_SPECIAL, 5'd31, 15'd0, FN_JR};
			default: return plain;
		endcase
	endfunction

	// operands for whatever sits in IF/ID until the next rising edge
	task automatic drive_operands();
		rs_val = $urandom;
		rt_val = $urandom;
		if (ifid.instr.r.op == OP_SPECIAL && ifid.instr.r.funct == FN_JR) begin
			rs_val = ($urandom % `MIPS_IMEM_DEPTH) << 2;
		end
		if ((ifid.instr.i.op == OP_BEQ || ifid.instr.i.op == OP_BNE) && $urandom % 2) begin
			rt_val = rs_val;
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) begin
			drive_operands();
			@(negedge clk);
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		void'($urandom(32'h6361_a704));
		nrst   = 1'b0;
		load   = '0;
		rs_val = '0;
		rt_val = '0;
		@(negedge clk);
		for (int w = 0; w < PROG_LEN; w++) begin
			load.we   = 1'b1;
			load.addr = w[`MIPS_IMEM_AW-1:0];
			load.data = program_word(w);
			@(negedge clk);
		end
		load = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		nrst = 1'b1;
		run_cycles(RUN_CYCLES);
		// reset again in the middle of the run
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		nrst = 1'b1;
		run_cycles(RERUN_CYCLES);
		total = mon_errors + uut.u_checker.fails;
		$display("monitor errors %0d, assertion failures %0d, total %0d",
			mon_errors, uut.u_checker.fails, total);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before the run finished");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
